// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// ==========================================================
	// Address and line geometry
	// ==========================================================

	// Fetch addresses are byte addresses
	localparam int ADDR_W = 32;

	// One cache line holds eight bytes of instruction data
	localparam int LINE_W = 64;
	localparam int OFS_W = 3;

	// Each bank holds 2**IDX_W sets
	localparam int IDX_W = 4;

	// The tag takes every bit above the set index and the parity bit
	localparam int TAG_W = ADDR_W - IDX_W - 1 - OFS_W;

	// The fill way field is sized for the widest supported bank
	localparam int MAX_WAYS = 4;
	localparam int WAY_W = $clog2(MAX_WAYS);

	// ==========================================================
	// Address views
	// ==========================================================

	// The parity bit picks the bank, even lines go to bank 0
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic par;
		logic [OFS_W-1:0] ofs;
	} addr_fields_t;

	// Same fetch word seen raw or split into cache fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		addr_fields_t f;
	} fetch_addr_u;

	typedef logic [LINE_W-1:0] line_data_t;

	// One-cycle fill strobe payload
	typedef struct packed {
		fetch_addr_u adr;
		logic [WAY_W-1:0] way;
		line_data_t data;
	} fill_t;

	// ==========================================================
	// Bank interface
	// ==========================================================

	// Read, write and invalidate requests to one parity bank
	typedef struct packed {
		logic rd_v;
		logic [TAG_W-1:0] rd_tag;
		logic [IDX_W-1:0] rd_idx;
		logic wr_v;
		logic [IDX_W-1:0] wr_idx;
		logic [WAY_W-1:0] wr_way;
		logic [TAG_W-1:0] wr_tag;
		line_data_t wr_data;
		logic inv_v;
		logic [IDX_W-1:0] inv_idx;
		logic inv_all;
	} bank_req_t;

	typedef struct packed {
		logic hit;
		line_data_t data;
	} bank_rsp_t;

	// A returned line carries its own line-aligned address
	typedef struct packed {
		fetch_addr_u adr;
		line_data_t data;
	} line_t;

	typedef struct packed {
		line_t hi;
		line_t lo;
	} line_pair_t;

endpackage

`default_nettype wire

// File: src/fetch_index.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_index #(
	parameter int WAYS = 2,
	parameter int LINES = 16
) (
	input wire clk,
	input wire rst,
	input wire fetch_v_i,
	input wire icache_pkg::fetch_addr_u fetch_adr_i,
	input wire fill_v_i,
	input wire icache_pkg::fill_t fill_i,
	input wire inv_line_i,
	input wire icache_pkg::fetch_addr_u inv_adr_i,
	input wire inv_all_i,
	output icache_pkg::bank_req_t even_req_o,
	output icache_pkg::bank_req_t odd_req_o,
	output logic pipe_v_o,
	output icache_pkg::fetch_addr_u pipe_adr_o
);

	localparam int IDX_W = icache_pkg::IDX_W;
	localparam int TAG_W = icache_pkg::TAG_W;

	logic wrap;
	logic [IDX_W-1:0] even_idx;
	logic [TAG_W-1:0] even_tag;
	logic fill_ok;
	logic fill_even;
	logic fill_odd;
	logic inv_even;
	logic inv_odd;

	// ==========================================================
	// Even bank read index
	// ==========================================================

	// A fetch in an odd line needs the next even line as its hi half
	// The last set wraps to set zero and carries into the tag
	always_comb begin
		wrap = fetch_adr_i.f.par && (fetch_adr_i.f.idx == IDX_W'(LINES - 1));
		even_idx = wrap ? '0 : fetch_adr_i.f.idx + IDX_W'(fetch_adr_i.f.par);
		even_tag = fetch_adr_i.f.tag + TAG_W'(wrap);
	end

	// Fills with a way number the banks do not have are dropped
	always_comb begin
		fill_ok = fill_v_i && (int'(fill_i.way) < WAYS);
		fill_even = fill_ok && !fill_i.adr.f.par;
		fill_odd = fill_ok && fill_i.adr.f.par;
		// A fill takes priority over a line invalidate aimed at its bank
		inv_even = inv_line_i && !inv_adr_i.f.par && !fill_even;
		inv_odd = inv_line_i && inv_adr_i.f.par && !fill_odd;
	end

	always_comb begin
		even_req_o.rd_v = fetch_v_i;
		even_req_o.rd_tag = even_tag;
		even_req_o.rd_idx = even_idx;
		even_req_o.wr_v = fill_even;
		even_req_o.wr_idx = fill_i.adr.f.idx;
		even_req_o.wr_way = fill_i.way;
		even_req_o.wr_tag = fill_i.adr.f.tag;
		even_req_o.wr_data = fill_i.data;
		even_req_o.inv_v = inv_even;
		even_req_o.inv_idx = inv_adr_i.f.idx;
		even_req_o.inv_all = inv_all_i;
		// The odd bank always reads the set of the fetch itself
		odd_req_o = even_req_o;
		odd_req_o.rd_tag = fetch_adr_i.f.tag;
		odd_req_o.rd_idx = fetch_adr_i.f.idx;
		odd_req_o.wr_v = fill_odd;
		odd_req_o.inv_v = inv_odd;
	end

	// Fetch address follows the bank read by one stage
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_v_o <= 1'b0;
		end else begin
			pipe_v_o <= fetch_v_i;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_v_i) begin
			pipe_adr_o <= fetch_adr_i;
		end
	end

endmodule

`default_nettype wire

// File: src/line_bank.sv
`timescale 1ns/1ns
`default_nettype none

module line_bank #(
	parameter int WAYS = 2,
	parameter int LINES = 16
) (
	input wire clk,
	input wire rst,
	input wire icache_pkg::bank_req_t req_i,
	output icache_pkg::bank_rsp_t rsp_o
);

	localparam int TAG_W = icache_pkg::TAG_W;

	// ==========================================================
	// Storage
	// ==========================================================

	// Tag and data arrays, one row of LINES entries per way
	logic [TAG_W-1:0] tag_mem [WAYS][LINES];
	icache_pkg::line_data_t data_mem [WAYS][LINES];

	// Valid bits live in flops so that one cycle can clear them all
	logic [WAYS-1:0][LINES-1:0] valid;

	// Read stage registers
	logic rd_v_q;
	logic [TAG_W-1:0] rd_tag_q;
	logic [TAG_W-1:0] way_tag_q [WAYS];
	icache_pkg::line_data_t way_data_q [WAYS];
	logic [WAYS-1:0] way_valid_q;

	// Compare results from the registered read
	logic [WAYS-1:0] way_hit;
	icache_pkg::line_data_t hit_data;

	// Only the named way takes the fill
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (req_i.wr_v && (int'(req_i.wr_way) == w)) begin
				tag_mem[w][req_i.wr_idx] <= req_i.wr_tag;
				data_mem[w][req_i.wr_idx] <= req_i.wr_data;
			end
		end
	end

	// ==========================================================
	// Valid bit maintenance
	// ==========================================================

	// Invalidate-all empties the bank exactly as reset does
	// A line invalidate clears the set in every way
	// The fill is ordered last so its own valid bit wins
	always_ff @(posedge clk) begin
		if (rst || req_i.inv_all) begin
			valid <= '0;
		end else begin
			if (req_i.inv_v) begin
				for (int w = 0; w < WAYS; w++) begin
					valid[w][req_i.inv_idx] <= 1'b0;
				end
			end
			if (req_i.wr_v) begin
				valid[req_i.wr_way][req_i.wr_idx] <= 1'b1;
			end
		end
	end

	// ==========================================================
	// Synchronous read
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_v_q <= 1'b0;
		end else begin
			rd_v_q <= req_i.rd_v;
		end
	end

	// Every way of the set is read at once
	// The request tag is kept alongside for the compare in the next cycle
	// A fill in the same cycle as the read is not seen until the next read
	always_ff @(posedge clk) begin
		if (req_i.rd_v) begin
			rd_tag_q <= req_i.rd_tag;
			for (int w = 0; w < WAYS; w++) begin
				way_tag_q[w] <= tag_mem[w][req_i.rd_idx];
				way_data_q[w] <= data_mem[w][req_i.rd_idx];
				way_valid_q[w] <= valid[w][req_i.rd_idx];
			end
		end
	end

	// Fills never put one tag into two ways of a set
	// so at most one way matches and the loop order does not matter
	always_comb begin
		hit_data = '0;
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = way_valid_q[w] && (way_tag_q[w] == rd_tag_q);
			if (way_hit[w]) begin
				hit_data = way_data_q[w];
			end
		end
	end

	// Miss when no valid way matches or no read was issued
	always_comb begin
		rsp_o.hit = rd_v_q && (|way_hit);
		rsp_o.data = hit_data;
	end

endmodule

`default_nettype wire

// File: src/line_pair_merge.sv
`timescale 1ns/1ns
`default_nettype none

module line_pair_merge (
	input wire pipe_v_i,
	input wire icache_pkg::fetch_addr_u pipe_adr_i,
	input wire icache_pkg::bank_rsp_t even_rsp_i,
	input wire icache_pkg::bank_rsp_t odd_rsp_i,
	output logic rsp_v_o,
	output logic hit_o,
	output icache_pkg::line_pair_t lines_o,
	output icache_pkg::fetch_addr_u miss_adr_o
);

	// Tag and set index together number a pair of lines
	localparam int PAIR_W = icache_pkg::TAG_W + icache_pkg::IDX_W;

	logic [PAIR_W-1:0] even_pair;
	icache_pkg::fetch_addr_u even_adr;
	icache_pkg::fetch_addr_u odd_adr;
	icache_pkg::line_t even_line;
	icache_pkg::line_t odd_line;

	// ==========================================================
	// Line addresses
	// ==========================================================

	// The even line is the fetch pair itself on parity 0
	// and the following pair on parity 1
	always_comb begin
		even_pair = {pipe_adr_i.f.tag, pipe_adr_i.f.idx} + PAIR_W'(pipe_adr_i.f.par);
		even_adr.raw = '0;
		{even_adr.f.tag, even_adr.f.idx} = even_pair;
		// odd line always shares the pair of the fetch
		odd_adr = pipe_adr_i;
		odd_adr.f.par = 1'b1;
		odd_adr.f.ofs = '0;
	end

	always_comb begin
		even_line.adr = even_adr;
		even_line.data = even_rsp_i.data;
		odd_line.adr = odd_adr;
		odd_line.data = odd_rsp_i.data;
	end

	// ==========================================================
	// Ordering and status
	// ==========================================================

	// Lo holds the fetch address and hi the line after it
	always_comb begin
		if (pipe_adr_i.f.par) begin
			lines_o.lo = odd_line;
			lines_o.hi = even_line;
		end else begin
			lines_o.lo = even_line;
			lines_o.hi = odd_line;
		end
	end

	// Both halves must be present for an instruction to cross a line
	always_comb begin
		rsp_v_o = pipe_v_i;
		hit_o = pipe_v_i && even_rsp_i.hit && odd_rsp_i.hit;
	end

	// The even bank is reported first when both banks miss
	// The refill engine then asks again for the odd line
	always_comb begin
		miss_adr_o.raw = '0;
		if (pipe_v_i && !even_rsp_i.hit) begin
			miss_adr_o = even_adr;
		end else if (pipe_v_i && !odd_rsp_i.hit) begin
			miss_adr_o = odd_adr;
		end
	end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
	parameter int WAYS = 2,
	parameter int LINES = 16
) (
	input wire clk,
	input wire rst,
	input wire fetch_v_i,
	input wire icache_pkg::fetch_addr_u fetch_adr_i,
	input wire fill_v_i,
	input wire icache_pkg::fill_t fill_i,
	input wire inv_line_i,
	input wire icache_pkg::fetch_addr_u inv_adr_i,
	input wire inv_all_i,
	output wire rsp_v_o,
	output wire hit_o,
	output wire icache_pkg::line_pair_t lines_o,
	output wire icache_pkg::fetch_addr_u miss_adr_o
);

	// ==========================================================
	// Request split
	// ==========================================================

	wire icache_pkg::bank_req_t even_req;
	wire icache_pkg::bank_req_t odd_req;
	wire icache_pkg::bank_rsp_t even_rsp;
	wire icache_pkg::bank_rsp_t odd_rsp;
	wire pipe_v;
	wire icache_pkg::fetch_addr_u pipe_adr;

	// Splits one fetch into two bank reads and steers fills by parity
	fetch_index #(
		.WAYS(WAYS),
		.LINES(LINES)
	) u_index (
		.clk(clk),
		.rst(rst),
		.fetch_v_i(fetch_v_i),
		.fetch_adr_i(fetch_adr_i),
		.fill_v_i(fill_v_i),
		.fill_i(fill_i),
		.inv_line_i(inv_line_i),
		.inv_adr_i(inv_adr_i),
		.inv_all_i(inv_all_i),
		.even_req_o(even_req),
		.odd_req_o(odd_req),
		.pipe_v_o(pipe_v),
		.pipe_adr_o(pipe_adr)
	);

	// ==========================================================
	// Parity banks
	// ==========================================================

	line_bank #(
		.WAYS(WAYS),
		.LINES(LINES)
	) u_even (
		.clk(clk),
		.rst(rst),
		.req_i(even_req),
		.rsp_o(even_rsp)
	);

	line_bank #(
		.WAYS(WAYS),
		.LINES(LINES)
	) u_odd (
		.clk(clk),
		.rst(rst),
		.req_i(odd_req),
		.rsp_o(odd_rsp)
	);

	// Bank results meet the delayed fetch address in the same cycle
	line_pair_merge u_merge (
		.pipe_v_i(pipe_v),
		.pipe_adr_i(pipe_adr),
		.even_rsp_i(even_rsp),
		.odd_rsp_i(odd_rsp),
		.rsp_v_o(rsp_v_o),
		.hit_o(hit_o),
		.lines_o(lines_o),
		.miss_adr_o(miss_adr_o)
	);

endmodule

`default_nettype wire

// File: verif/icache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module icache_checker (
	input wire clk,
	input wire rst,
	input wire fetch_v_i,
	input wire rsp_v_o,
	input wire hit_o
);

	int fail_cnt = 0;

	// No response leaves the cache while reset is held, nor in the cycle after it
	reset_quiet: assert property (@(posedge clk) rst |=> !rsp_v_o)
		else begin
			$error("response valid during reset or in the cycle after it");
			fail_cnt++;
		end

	// ==========================================================
	// Fetch to response timing
	// ==========================================================

	// Every accepted fetch answers exactly one cycle later
	fetch_answered: assert property (@(posedge clk) disable iff (rst)
		fetch_v_i |=> rsp_v_o)
		else begin
			$error("fetch not answered one cycle later");
			fail_cnt++;
		end

	// and nothing answers when no fetch was presented
	no_fetch_quiet: assert property (@(posedge clk) disable iff (rst)
		!fetch_v_i |=> !rsp_v_o)
		else begin
			$error("response valid without a fetch one cycle earlier");
			fail_cnt++;
		end

	// A hit is only meaningful on a valid response
	hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
		hit_o |-> rsp_v_o)
		else begin
			$error("hit reported without a valid response");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// File: verif/tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache;

	localparam string GOLDEN_FILE = "verif/icache_golden.txt";
	localparam int MAX_OPS = 64;
	localparam int COLS = 8;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_MARGIN = 40;

	// Operation codes in the first column of the golden file
	localparam logic [3:0] OP_END = 4'd0;
	localparam logic [3:0] OP_FILL = 4'd1;
	localparam logic [3:0] OP_INV = 4'd2;
	localparam logic [3:0] OP_INV_ALL = 4'd3;
	localparam logic [3:0] OP_FETCH = 4'd4;
	localparam logic [3:0] OP_FETCH_B2B = 4'd5;

	logic clk;
	logic rst;
	logic fetch_v;
	icache_pkg::fetch_addr_u fetch_adr;
	logic fill_v;
	icache_pkg::fill_t fill_d;
	logic inv_line;
	icache_pkg::fetch_addr_u inv_adr;
	logic inv_all;
	wire rsp_v;
	wire hit;
	wire icache_pkg::line_pair_t lines;
	wire icache_pkg::fetch_addr_u miss_adr;

	// Eight words per operation: op adr way data hit lo hi miss
	logic [63:0] gold [MAX_OPS*COLS];

	integer seed;
	int errors;
	int tests;
	int passed;
	int cycles;
	int limit;
	int pend_idx;
	logic pend_v;

	icache_top #(
		.WAYS(2),
		.LINES(16)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.fetch_v_i(fetch_v),
		.fetch_adr_i(fetch_adr),
		.fill_v_i(fill_v),
		.fill_i(fill_d),
		.inv_line_i(inv_line),
		.inv_adr_i(inv_adr),
		.inv_all_i(inv_all),
		.rsp_v_o(rsp_v),
		.hit_o(hit),
		.lines_o(lines),
		.miss_adr_o(miss_adr)
	);

	bind icache_top icache_checker u_checker (
		.clk(clk),
		.rst(rst),
		.fetch_v_i(fetch_v_i),
		.rsp_v_o(rsp_v_o),
		.hit_o(hit_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Hard stop in case the operation loop ever stalls
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [63:0] gold_word(input int idx, input int col);
		return gold[idx*COLS + col];
	endfunction

	// ==========================================================
	// Compare tasks
	// ==========================================================

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_addr(input string name, input icache_pkg::fetch_addr_u got,
			input icache_pkg::fetch_addr_u exp);
		if (got.raw !== exp.raw) begin
			$display("FAILED %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
			errors++;
		end
	endtask

	task automatic compare_lines(input string name, input icache_pkg::line_pair_t got,
			input icache_pkg::line_pair_t exp);
		if (got !== exp) begin
			$display("FAILED %0t %s got lo %h:%h hi %h:%h expected lo %h:%h hi %h:%h",
				$time, name, got.lo.adr.raw, got.lo.data, got.hi.adr.raw, got.hi.data,
				exp.lo.adr.raw, exp.lo.data, exp.hi.adr.raw, exp.hi.data);
			errors++;
		end
	endtask

	// Expected response of one golden fetch line
	task automatic check_fetch(input int idx);
		icache_pkg::fetch_addr_u fetch_a;
		icache_pkg::fetch_addr_u exp_miss;
		icache_pkg::line_pair_t exp_lines;
		logic [63:0] w;
		logic exp_hit;
		int errs_before;
		errs_before = errors;
		w = gold_word(idx, 1);
		fetch_a.raw = w[31:0];
		w = gold_word(idx, 4);
		exp_hit = w[0];
		// Lo is the line holding the fetch, hi the next line in address order
		exp_lines.lo.adr.raw = fetch_a.raw & ~((32'd1 << icache_pkg::OFS_W) - 32'd1);
		exp_lines.hi.adr.raw = exp_lines.lo.adr.raw + (32'd1 << icache_pkg::OFS_W);
		exp_lines.lo.data = gold_word(idx, 5);
		exp_lines.hi.data = gold_word(idx, 6);
		w = gold_word(idx, 7);
		exp_miss.raw = w[31:0];
		tests++;
		compare_bit("rsp_v_o", rsp_v, 1'b1);
		compare_bit("hit_o", hit, exp_hit);
		// Line data carries no meaning on a miss
		if (exp_hit) begin
			compare_lines("lines_o", lines, exp_lines);
		end
		compare_addr("miss_adr_o", miss_adr, exp_miss);
		if (errors == errs_before) begin
			passed++;
			$display("test %0d fetch %h ok", tests, fetch_a.raw);
		end else begin
			$display("test %0d fetch %h wrong in %0d values", tests, fetch_a.raw,
				errors - errs_before);
		end
	endtask

	// ==========================================================
	// One clock cycle of stimulus
	// ==========================================================

	// An index below zero makes an idle cycle
	// The fetch driven one cycle earlier is checked at the falling edge
	task automatic run_cycle(input int idx);
		logic [63:0] w;
		logic [3:0] op;
		op = OP_END;
		if (idx >= 0) begin
			w = gold_word(idx, 0);
			op = w[3:0];
		end
		@(posedge clk);
		fetch_v <= 1'b0;
		fill_v <= 1'b0;
		inv_line <= 1'b0;
		inv_all <= 1'b0;
		case (op)
			OP_END: begin
			end
			OP_FILL: begin
				w = gold_word(idx, 1);
				fill_d.adr.raw <= w[31:0];
				w = gold_word(idx, 2);
				fill_d.way <= w[icache_pkg::WAY_W-1:0];
				fill_d.data <= gold_word(idx, 3);
				fill_v <= 1'b1;
			end
			OP_INV: begin
				w = gold_word(idx, 1);
				inv_adr.raw <= w[31:0];
				inv_line <= 1'b1;
			end
			OP_INV_ALL: begin
				inv_all <= 1'b1;
			end
			OP_FETCH, OP_FETCH_B2B: begin
				w = gold_word(idx, 1);
				fetch_adr.raw <= w[31:0];
				fetch_v <= 1'b1;
			end
			default: begin
				$display("Golden line %0d holds unknown operation %0h", idx, op);
				errors++;
			end
		endcase
		@(negedge clk);
		if (pend_v) begin
			check_fetch(pend_idx);
		end
		pend_v = (op == OP_FETCH) || (op == OP_FETCH_B2B);
		pend_idx = idx;
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		int op_cnt;
		int gap;
		logic [63:0] w;
		seed = 69498;
		errors = 0;
		tests = 0;
		passed = 0;
		cycles = 0;
		pend_v = 1'b0;
		pend_idx = 0;
		rst = 1'b1;
		// Fetches presented while reset is held must not produce a response
		fetch_v = 1'b1;
		fetch_adr = '0;
		fill_v = 1'b0;
		fill_d = '0;
		inv_line = 1'b0;
		inv_adr = '0;
		inv_all = 1'b0;
		for (int i = 0; i < MAX_OPS*COLS; i++) begin
			gold[i] = '0;
		end
		$readmemh(GOLDEN_FILE, gold);
		// The first end marker closes the operation list
		op_cnt = MAX_OPS;
		for (int i = MAX_OPS - 1; i >= 0; i--) begin
			w = gold_word(i, 0);
			if (w[3:0] == OP_END) begin
				op_cnt = i;
			end
		end
		if (op_cnt == 0) begin
			$display("Golden file holds no operations");
			errors++;
		end
		limit = op_cnt * 8 + RESET_CYCLES + TIMEOUT_MARGIN;
		// The fetch drops two cycles before release so none straddles the end of reset
		repeat (RESET_CYCLES - 2) @(posedge clk);
		fetch_v <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < op_cnt; i++) begin
			w = gold_word(i, 0);
			// Back-to-back fetches skip the idle gap
			if (w[3:0] != OP_FETCH_B2B) begin
				gap = {$random(seed)} % 4;
				repeat (gap) run_cycle(-1);
			end
			run_cycle(i);
		end
		run_cycle(-1);
		run_cycle(-1);
		errors += dut0.u_checker.fail_cnt;
		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests, passed,
			tests - passed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/icache_golden.txt
// op adr way data hit lo_data hi_data miss_adr, all hex
// op 1 fill, 2 invalidate line, 3 invalidate all, 4 fetch, 5 fetch right after the last, 0 end
// pair of lines and parity 1 fetch
1 00001020 0 a0a0a0a000001020 0 0 0 0
1 00001028 0 b1b1b1b100001028 0 0 0 0
4 00001024 0 0 1 a0a0a0a000001020 b1b1b1b100001028 00000000
1 00001030 1 c2c2c2c200001030 0 0 0 0
4 0000102c 0 0 1 b1b1b1b100001028 c2c2c2c200001030 00000000
1 000010f8 0 d3d3d3d3000010f8 0 0 0 0
1 00001100 1 e4e4e4e400001100 0 0 0 0
4 000010fc 0 0 1 d3d3d3d3000010f8 e4e4e4e400001100 00000000
// misses
4 00001044 0 0 0 0 0 00001040
1 00001040 0 f5f5f5f500001040 0 0 0 0
4 00001040 0 0 0 0 0 00001048
// ways of one set and replacement
1 00001050 0 0606060600001050 0 0 0 0
1 00002050 1 1717171700002050 0 0 0 0
1 00001058 0 2828282800001058 0 0 0 0
1 00002058 1 3939393900002058 0 0 0 0
4 00001050 0 0 1 0606060600001050 2828282800001058 00000000
4 00002054 0 0 1 1717171700002050 3939393900002058 00000000
1 00002050 1 4a4a4a4a00002050 0 0 0 0
4 00002052 0 0 1 4a4a4a4a00002050 3939393900002058 00000000
1 00003050 0 5b5b5b5b00003050 0 0 0 0
4 00001050 0 0 0 0 0 00001050
// invalidation
2 00001028 0 0 0 0 0 0
4 00001020 0 0 0 0 0 00001028
4 0000102c 0 0 0 0 0 00001028
4 00002050 0 0 1 4a4a4a4a00002050 3939393900002058 00000000
3 00000000 0 0 0 0 0 0
4 00002050 0 0 0 0 0 00002050
4 000010fc 0 0 0 0 0 00001100
// back-to-back fetches
1 00001060 0 6c6c6c6c00001060 0 0 0 0
1 00001068 0 7d7d7d7d00001068 0 0 0 0
1 00001070 1 8e8e8e8e00001070 0 0 0 0
4 00001060 0 0 1 6c6c6c6c00001060 7d7d7d7d00001068 00000000
5 0000106c 0 0 1 7d7d7d7d00001068 8e8e8e8e00001070 00000000
5 00001080 0 0 0 0 0 00001080
5 00001066 0 0 1 6c6c6c6c00001060 7d7d7d7d00001068 00000000
0 00000000 0 0 0 0 0 0

// File: build.f
src/icache_pkg.sv
src/fetch_index.sv
src/line_bank.sv
src/line_pair_merge.sv
src/icache_top.sv
verif/icache_checker.sv
verif/tb_icache.sv

// File: Makefile
SIM := obj_dir/sim_icache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -Wno-fatal -f build.f --top-module tb_icache -o sim_icache

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module tb_icache

clean:
	rm -rf obj_dir
